/* src/ising_defines.svh */
`ifndef ISING_DEFINES_SVH
`define ISING_DEFINES_SVH

// Problem size
`define ISING_NUM_SPIN 8

// Signed coupling weight width
`define ISING_BIT_J 4

// Signed bias width
`define ISING_BIT_H 8

`define ISING_ENERGY_W 16

// Host register data width
`define ISING_REG_DW 16

// Result queue entries
`define ISING_QUEUE_DEPTH 4

// Credits the consumer grants after reset
`define ISING_MAX_CREDITS 2

`endif

/* src/ising_pkg.sv */
package ising_pkg;

`include "ising_defines.svh"

    // Bit 1 is spin +1, bit 0 is spin -1
    typedef logic [`ISING_NUM_SPIN-1:0] spin_t;

    // Weight j at bit offset j*ISING_BIT_J
    typedef logic [`ISING_NUM_SPIN*`ISING_BIT_J-1:0] j_row_t;
    typedef logic [$clog2(`ISING_NUM_SPIN)-1:0] j_addr_t;

    typedef logic signed [`ISING_BIT_H-1:0] hbias_t;
    typedef logic signed [`ISING_ENERGY_W-1:0] energy_t;

    // Host register map
    typedef enum logic [1:0] {
        REG_CTRL   = 2'd0,
        REG_SPIN   = 2'd1,
        REG_HBIAS  = 2'd2,
        REG_STATUS = 2'd3
    } reg_addr_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_PUSH = 2'd2
    } engine_state_e;

endpackage

/* src/ising_reg_file.sv */
`include "ising_defines.svh"

module ising_reg_file (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     reg_valid_i,
    input  logic                     reg_write_i,
    input  ising_pkg::reg_addr_e     reg_addr_i,
    input  logic [`ISING_REG_DW-1:0] reg_wdata_i,
    output logic [`ISING_REG_DW-1:0] reg_rdata_o,
    output logic                     reg_rvalid_o,
    input  logic                     engine_idle_i,
    input  logic [2:0]               queue_count_i,
    output logic                     start_o,
    output ising_pkg::spin_t         spin_o,
    output ising_pkg::hbias_t        hbias_o
);
    import ising_pkg::*;

    spin_t                    spin_q;
    hbias_t                   hbias_q;
    logic                     start_q;
    logic                     rvalid_q;
    logic [`ISING_REG_DW-1:0] rdata_q;
    logic [`ISING_REG_DW-1:0] rdata_d;
    logic                     wr_en;
    logic                     rd_en;

    assign wr_en = reg_valid_i && reg_write_i;
    assign rd_en = reg_valid_i && !reg_write_i;

    // Read mux, status is sampled live
    always_comb begin
        rdata_d = '0;
        case (reg_addr_i)
            REG_SPIN:   rdata_d[`ISING_NUM_SPIN-1:0] = spin_q;
            REG_HBIAS:  rdata_d[`ISING_BIT_H-1:0] = hbias_q;
            REG_STATUS: rdata_d[3:0] = {queue_count_i, engine_idle_i};
            default:    rdata_d = '0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            spin_q   <= '0;
            hbias_q  <= '0;
            start_q  <= 1'b0;
            rvalid_q <= 1'b0;
        end else begin
            // One-cycle start pulse
            start_q  <= wr_en && (reg_addr_i == REG_CTRL) && reg_wdata_i[0];
            rvalid_q <= rd_en;
            if (wr_en && (reg_addr_i == REG_SPIN)) begin
                spin_q <= reg_wdata_i[`ISING_NUM_SPIN-1:0];
            end
            if (wr_en && (reg_addr_i == REG_HBIAS)) begin
                hbias_q <= reg_wdata_i[`ISING_BIT_H-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (rd_en) begin
            rdata_q <= rdata_d;
        end
    end

    assign reg_rdata_o  = rdata_q;
    assign reg_rvalid_o = rvalid_q;
    assign start_o      = start_q;
    assign spin_o       = spin_q;
    assign hbias_o      = hbias_q;

endmodule

/* src/coupling_mem.sv */
`include "ising_defines.svh"

module coupling_mem (
    input  logic               clk_i,
    input  logic               wr_en_i,
    input  ising_pkg::j_addr_t waddr_i,
    input  ising_pkg::j_row_t  wdata_i,
    input  logic               rd_en_i,
    input  ising_pkg::j_addr_t raddr_i,
    output ising_pkg::j_row_t  rdata_o
);
    import ising_pkg::*;

    // One row of weights per spin
    j_row_t mem_q [`ISING_NUM_SPIN];
    j_row_t rdata_q;

    // Host load port
    always_ff @(posedge clk_i) begin
        if (wr_en_i) begin
            mem_q[waddr_i] <= wdata_i;
        end
    end

    // Engine port, same-row collision reads the old row
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rdata_q <= mem_q[raddr_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

/* src/energy_engine.sv */
`include "ising_defines.svh"

module energy_engine (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               start_i,
    input  ising_pkg::spin_t   spin_i,
    input  ising_pkg::hbias_t  hbias_i,
    output logic               rd_en_o,
    output ising_pkg::j_addr_t raddr_o,
    input  ising_pkg::j_row_t  rdata_i,
    input  logic               full_i,
    output logic               push_o,
    output ising_pkg::energy_t energy_o,
    output logic               idle_o
);
    import ising_pkg::*;

    localparam j_addr_t LAST_ROW = j_addr_t'(`ISING_NUM_SPIN - 1);

    engine_state_e state_q;
    j_addr_t       cnt_q;
    logic          issue_done_q;
    logic          rd_valid_q;
    j_addr_t       row_q;
    spin_t         spin_q;
    hbias_t        hbias_q;
    energy_t       acc_q;
    energy_t       row_term;
    energy_t       spin_sum;

    // Sum over j of J[i][j] * sigma_j
    function automatic energy_t row_dot(input j_row_t row, input spin_t s);
        energy_t sum;
        energy_t w;
        sum = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            w   = energy_t'(signed'(row[j*`ISING_BIT_J +: `ISING_BIT_J]));
            sum = s[j] ? sum + w : sum - w;
        end
        return sum;
    endfunction

    // Sum of sigma, 2*ones - N
    function automatic energy_t sigma_sum(input spin_t s);
        energy_t ones;
        ones = '0;
        for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
            ones = ones + energy_t'(s[j]);
        end
        return (ones <<< 1) - energy_t'(`ISING_NUM_SPIN);
    endfunction

    //////////////////////////////////////////////////
    // Row sequencing
    //////////////////////////////////////////////////
    assign rd_en_o = (state_q == ST_RUN) && !issue_done_q;
    assign raddr_o = cnt_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= ST_IDLE;
            cnt_q        <= '0;
            issue_done_q <= 1'b0;
            rd_valid_q   <= 1'b0;
            row_q        <= '0;
        end else begin
            rd_valid_q <= rd_en_o;
            row_q      <= raddr_o;
            case (state_q)
                ST_IDLE: begin
                    if (start_i) begin
                        state_q      <= ST_RUN;
                        cnt_q        <= '0;
                        issue_done_q <= 1'b0;
                    end
                end
                ST_RUN: begin
                    if (rd_en_o) begin
                        cnt_q <= cnt_q + j_addr_t'(1);
                        if (cnt_q == LAST_ROW) begin
                            issue_done_q <= 1'b1;
                        end
                    end
                    // Last row lands this cycle
                    if (rd_valid_q && (row_q == LAST_ROW)) begin
                        state_q <= ST_PUSH;
                    end
                end
                ST_PUSH: begin
                    if (!full_i) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Accumulator
    //////////////////////////////////////////////////
    assign row_term = row_dot(rdata_i, spin_q);

    always_ff @(posedge clk_i) begin
        if ((state_q == ST_IDLE) && start_i) begin
            spin_q  <= spin_i;
            hbias_q <= hbias_i;
            acc_q   <= '0;
        end else if (rd_valid_q) begin
            acc_q <= spin_q[row_q] ? acc_q + row_term : acc_q - row_term;
        end
    end

    assign spin_sum = sigma_sum(spin_q);
    assign energy_o = -acc_q - (energy_t'(hbias_q) * spin_sum);
    assign push_o   = (state_q == ST_PUSH) && !full_i;
    assign idle_o   = (state_q == ST_IDLE);

endmodule

/* src/energy_out_queue.sv */
`include "ising_defines.svh"

module energy_out_queue (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               push_i,
    input  ising_pkg::energy_t push_data_i,
    output logic               full_o,
    output logic [2:0]         count_o,
    input  logic               credit_i,
    output logic               energy_valid_o,
    output ising_pkg::energy_t energy_o
);
    import ising_pkg::*;

    localparam int DEPTH  = `ISING_QUEUE_DEPTH;
    localparam int PTR_W  = $clog2(DEPTH);
    localparam int CRED_W = $clog2(`ISING_MAX_CREDITS + 1);

    energy_t           mem_q [DEPTH];
    logic [PTR_W-1:0]  wr_ptr_q;
    logic [PTR_W-1:0]  rd_ptr_q;
    logic [2:0]        count_q;
    logic [CRED_W-1:0] credit_q;
    logic              valid_q;
    energy_t           data_q;
    logic              push_ok;
    logic              pop;
    logic              bypass;
    logic              store;
    logic              drain;

    assign full_o  = (count_q == 3'(DEPTH));
    assign push_ok = push_i && !full_o;

    // Empty queue hands a fresh push straight to the link
    assign pop    = (credit_q != '0) && ((count_q != '0) || push_ok);
    assign bypass = pop && (count_q == '0);
    assign store  = push_ok && !bypass;
    assign drain  = pop && !bypass;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
            credit_q <= CRED_W'(`ISING_MAX_CREDITS);
            valid_q  <= 1'b0;
        end else begin
            valid_q <= pop;
            if (store) begin
                wr_ptr_q <= wr_ptr_q + PTR_W'(1);
            end
            if (drain) begin
                rd_ptr_q <= rd_ptr_q + PTR_W'(1);
            end
            count_q <= count_q + 3'(store) - 3'(drain);
            // One credit spent per word, one back per pulse
            case ({pop, credit_i})
                2'b10:   credit_q <= credit_q - CRED_W'(1);
                2'b01:   credit_q <= credit_q + CRED_W'(1);
                default: credit_q <= credit_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (store) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
        if (pop) begin
            data_q <= bypass ? push_data_i : mem_q[rd_ptr_q];
        end
    end

    assign count_o        = count_q;
    assign energy_valid_o = valid_q;
    assign energy_o       = data_q;

endmodule

/* src/ising_core_top.sv */
`include "ising_defines.svh"

module ising_core_top (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     reg_valid_i,
    input  logic                     reg_write_i,
    input  ising_pkg::reg_addr_e     reg_addr_i,
    input  logic [`ISING_REG_DW-1:0] reg_wdata_i,
    output logic [`ISING_REG_DW-1:0] reg_rdata_o,
    output logic                     reg_rvalid_o,
    input  logic                     j_wr_en_i,
    input  ising_pkg::j_addr_t       j_waddr_i,
    input  ising_pkg::j_row_t        j_wdata_i,
    input  logic                     credit_i,
    output logic                     energy_valid_o,
    output ising_pkg::energy_t       energy_o
);
    import ising_pkg::*;

    logic       start;
    spin_t      spin;
    hbias_t     hbias;
    logic       engine_idle;
    logic [2:0] queue_count;
    logic       j_rd_en;
    j_addr_t    j_raddr;
    j_row_t     j_rdata;
    logic       q_full;
    logic       q_push;
    energy_t    q_energy;

    //////////////////////////////////////////////////
    // Host side
    //////////////////////////////////////////////////
    ising_reg_file u_reg_file (
        .clk_i         (clk_i        ),
        .rst_n_i       (rst_n_i      ),
        .reg_valid_i   (reg_valid_i  ),
        .reg_write_i   (reg_write_i  ),
        .reg_addr_i    (reg_addr_i   ),
        .reg_wdata_i   (reg_wdata_i  ),
        .reg_rdata_o   (reg_rdata_o  ),
        .reg_rvalid_o  (reg_rvalid_o ),
        .engine_idle_i (engine_idle  ),
        .queue_count_i (queue_count  ),
        .start_o       (start        ),
        .spin_o        (spin         ),
        .hbias_o       (hbias        )
    );

    coupling_mem u_coupling_mem (
        .clk_i   (clk_i    ),
        .wr_en_i (j_wr_en_i),
        .waddr_i (j_waddr_i),
        .wdata_i (j_wdata_i),
        .rd_en_i (j_rd_en  ),
        .raddr_i (j_raddr  ),
        .rdata_o (j_rdata  )
    );

    //////////////////////////////////////////////////
    // Compute and output link
    //////////////////////////////////////////////////
    energy_engine u_energy_engine (
        .clk_i    (clk_i      ),
        .rst_n_i  (rst_n_i    ),
        .start_i  (start      ),
        .spin_i   (spin       ),
        .hbias_i  (hbias      ),
        .rd_en_o  (j_rd_en    ),
        .raddr_o  (j_raddr    ),
        .rdata_i  (j_rdata    ),
        .full_i   (q_full     ),
        .push_o   (q_push     ),
        .energy_o (q_energy   ),
        .idle_o   (engine_idle)
    );

    energy_out_queue u_energy_out_queue (
        .clk_i          (clk_i         ),
        .rst_n_i        (rst_n_i       ),
        .push_i         (q_push        ),
        .push_data_i    (q_energy      ),
        .full_o         (q_full        ),
        .count_o        (queue_count   ),
        .credit_i       (credit_i      ),
        .energy_valid_o (energy_valid_o),
        .energy_o       (energy_o      )
    );

endmodule

/* tests/ising_core_tb.sv */
`include "ising_defines.svh"

module ising_core_tb;
    import ising_pkg::*;

    localparam int NUM_ENTRIES     = 6;
    localparam int WATCHDOG_CYCLES = NUM_ENTRIES * 40 + 200;
    localparam int WAIT_LIMIT      = 64;

    typedef struct packed {
        logic [`ISING_NUM_SPIN-1:0] spin;
        logic signed [7:0]          h;
        logic                       reload;
        logic signed [15:0]         expected;
    } vec_t;

    logic                     clk;
    logic                     rst_n;
    logic                     reg_valid_i;
    logic                     reg_write_i;
    reg_addr_e                reg_addr_i;
    logic [`ISING_REG_DW-1:0] reg_wdata_i;
    logic [`ISING_REG_DW-1:0] reg_rdata_o;
    logic                     reg_rvalid_o;
    logic                     j_wr_en_i;
    j_addr_t                  j_waddr_i;
    j_row_t                   j_wdata_i;
    logic                     credit_i;
    logic                     energy_valid_o;
    energy_t                  energy_o;

    vec_t   tbl [NUM_ENTRIES];
    j_row_t j_shadow [`ISING_NUM_SPIN];
    int     exp_q [$];
    int     rx_cnt;
    int     pending_credits;
    logic   credit_en;
    integer seed = 25635;

    ising_core_top ising_core_top_i (
        .clk_i          (clk           ),
        .rst_n_i        (rst_n         ),
        .reg_valid_i    (reg_valid_i   ),
        .reg_write_i    (reg_write_i   ),
        .reg_addr_i     (reg_addr_i    ),
        .reg_wdata_i    (reg_wdata_i   ),
        .reg_rdata_o    (reg_rdata_o   ),
        .reg_rvalid_o   (reg_rvalid_o  ),
        .j_wr_en_i      (j_wr_en_i     ),
        .j_waddr_i      (j_waddr_i     ),
        .j_wdata_i      (j_wdata_i     ),
        .credit_i       (credit_i      ),
        .energy_valid_o (energy_valid_o),
        .energy_o       (energy_o      )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////
    task automatic stop_with_error();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            $display("MISMATCH at time %0t: %s, got %0d, expected %0d",
                     $time, what, actual, expected);
            stop_with_error();
        end
    endtask

    // Energy = -sum J[i][j]*si*sj - h*sum si
    function automatic int ref_energy(input logic [`ISING_NUM_SPIN-1:0] s, input hbias_t h);
        int                             acc;
        int                             ssum;
        int                             si;
        int                             sj;
        int                             hv;
        logic signed [`ISING_BIT_J-1:0] w;
        acc  = 0;
        ssum = 0;
        hv   = h;
        for (int i = 0; i < `ISING_NUM_SPIN; i++) begin
            si   = s[i] ? 1 : -1;
            ssum = ssum + si;
            for (int j = 0; j < `ISING_NUM_SPIN; j++) begin
                sj  = s[j] ? 1 : -1;
                w   = j_shadow[i][j*`ISING_BIT_J +: `ISING_BIT_J];
                acc = acc + int'(w) * si * sj;
            end
        end
        return -acc - hv * ssum;
    endfunction

    function automatic void set_entry(input int idx, input logic [7:0] s,
                                      input logic signed [7:0] h, input logic reload);
        tbl[idx].spin     = s;
        tbl[idx].h        = h;
        tbl[idx].reload   = reload;
        tbl[idx].expected = '0;
    endfunction

    task automatic reg_write(input reg_addr_e addr, input logic [`ISING_REG_DW-1:0] data);
        reg_valid_i = 1'b1;
        reg_write_i = 1'b1;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        @(posedge clk);
        #1;
        reg_valid_i = 1'b0;
        reg_write_i = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_e addr, output logic [`ISING_REG_DW-1:0] data);
        reg_valid_i = 1'b1;
        reg_write_i = 1'b0;
        reg_addr_i  = addr;
        @(posedge clk);
        #1;
        reg_valid_i = 1'b0;
        check(int'(reg_rvalid_o), 1, "read data valid");
        data = reg_rdata_o;
    endtask

    task automatic load_j();
        for (int r = 0; r < `ISING_NUM_SPIN; r++) begin
            j_shadow[r] = $random(seed);
            j_wr_en_i   = 1'b1;
            j_waddr_i   = j_addr_t'(r);
            j_wdata_i   = j_shadow[r];
            @(posedge clk);
            #1;
        end
        j_wr_en_i = 1'b0;
    endtask

    // Start pulse reaches the engine one cycle after the write
    task automatic start_run(input logic [7:0] s, input hbias_t h, input int expected);
        exp_q.push_back(expected);
        reg_write(REG_SPIN, {8'h00, s});
        reg_write(REG_HBIAS, {8'h00, h});
        reg_write(REG_CTRL, 16'h0001);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic wait_idle(output logic [`ISING_REG_DW-1:0] status);
        int polls;
        polls = 0;
        reg_read(REG_STATUS, status);
        while (!status[0] && polls < WAIT_LIMIT) begin
            reg_read(REG_STATUS, status);
            polls++;
        end
        if (!status[0]) begin
            $display("Engine never returned to idle at time %0t", $time);
            stop_with_error();
        end
    endtask

    task automatic wait_words(input int n);
        int cycles;
        cycles = 0;
        while (rx_cnt < n && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (rx_cnt < n) begin
            $display("Timed out waiting for output word %0d at time %0t", n, $time);
            stop_with_error();
        end
    endtask

    // Let the consumer hand back every credit it owes
    task automatic drain_credits();
        int cycles;
        cycles = 0;
        while (pending_credits != 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (pending_credits != 0) begin
            $display("Credits were never returned to the queue");
            stop_with_error();
        end
        repeat (2) @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////
    // Consumer
    //////////////////////////////////////////////////
    always @(negedge clk) begin
        if (energy_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Output word %0d arrived with no run pending", energy_o);
                stop_with_error();
            end else begin
                check(int'(energy_o), exp_q.pop_front(), "output energy");
                rx_cnt++;
                pending_credits++;
            end
        end
    end

    initial begin
        credit_i = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            credit_i = credit_en && (pending_credits > 0);
            if (credit_i) begin
                pending_credits--;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Simulation timed out after %0d clock cycles", WATCHDOG_CYCLES);
        stop_with_error();
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////
    initial begin
        logic [`ISING_REG_DW-1:0] rd;
        int                       base;
        rst_n           = 1'b0;
        reg_valid_i     = 1'b0;
        reg_write_i     = 1'b0;
        reg_addr_i      = REG_CTRL;
        reg_wdata_i     = '0;
        j_wr_en_i       = 1'b0;
        j_waddr_i       = '0;
        j_wdata_i       = '0;
        credit_en       = 1'b1;
        rx_cnt          = 0;
        pending_credits = 0;
        set_entry(0, 8'h00, 8'sd0, 1'b1);
        set_entry(1, 8'hFF, 8'sd3, 1'b0);
        set_entry(2, 8'hFF, 8'sd3, 1'b1);
        set_entry(3, 8'hA5, -8'sd5, 1'b0);
        set_entry(4, 8'h3C, 8'sd127, 1'b1);
        set_entry(5, 8'h81, -8'sd128, 0);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Reset state and register readback
        check(int'(energy_valid_o), 0, "valid after reset");
        reg_read(REG_SPIN, rd);
        check(int'(rd), 0, "spin after reset");
        reg_read(REG_HBIAS, rd);
        check(int'(rd), 0, "bias after reset");
        reg_read(REG_STATUS, rd);
        check(int'(rd), 1, "status after reset");
        reg_write(REG_SPIN, 16'h00A5);
        reg_write(REG_HBIAS, 16'h00F3);
        reg_read(REG_SPIN, rd);
        check(int'(rd), 16'h00A5, "spin readback");
        reg_read(REG_HBIAS, rd);
        check(int'(rd), 16'h00F3, "bias readback");

        // One energy per table entry
        for (int k = 0; k < NUM_ENTRIES; k++) begin
            if (tbl[k].reload) begin
                load_j();
            end
            tbl[k].expected = 16'(ref_energy(tbl[k].spin, tbl[k].h));
            base = rx_cnt;
            start_run(tbl[k].spin, tbl[k].h, int'(tbl[k].expected));
            wait_words(base + 1);
            wait_idle(rd);
            check(int'(rd), 1, "status after run");
        end

        // Credits withheld over three runs
        drain_credits();
        credit_en = 1'b0;
        base      = rx_cnt;
        for (int k = 0; k < 3; k++) begin
            start_run(tbl[k].spin, tbl[k].h, ref_energy(tbl[k].spin, tbl[k].h));
            wait_idle(rd);
        end
        repeat (4) @(posedge clk);
        #1;
        check(rx_cnt, base + `ISING_MAX_CREDITS, "words sent without credits");
        reg_read(REG_STATUS, rd);
        check(int'(rd), 16'h0003, "status with one word queued");
        credit_en = 1'b1;
        wait_words(base + 3);
        wait_idle(rd);
        check(int'(rd), 1, "status after credit return");

        // Stall the engine behind a full queue
        drain_credits();
        credit_en = 1'b0;
        base      = rx_cnt;
        for (int k = 0; k < 6; k++) begin
            start_run(tbl[k % NUM_ENTRIES].spin, tbl[k % NUM_ENTRIES].h,
                      ref_energy(tbl[k % NUM_ENTRIES].spin, tbl[k % NUM_ENTRIES].h));
            wait_idle(rd);
        end
        start_run(tbl[0].spin, tbl[0].h, ref_energy(tbl[0].spin, tbl[0].h));
        repeat (16) @(posedge clk);
        #1;
        reg_read(REG_STATUS, rd);
        check(int'(rd), 16'h0008, "status while engine stalled");
        check(rx_cnt, base + `ISING_MAX_CREDITS, "words sent while stalled");
        credit_en = 1'b1;
        wait_words(base + 7);
        wait_idle(rd);
        check(int'(rd), 1, "status after stall clears");

        $display("Finished with no errors");
        $finish;
    end

endmodule

/* list.f */
+incdir+src
src/ising_pkg.sv
src/ising_reg_file.sv
src/coupling_mem.sv
src/energy_engine.sv
src/energy_out_queue.sv
src/ising_core_top.sv
tests/ising_core_tb.sv
